/* tests/la_int_core_golden.txt */
# each line holds inst, pc and the expected ine, we, rd and value, all in hex.
# value is compared only when we is 1.
02BFFC01 1C000000 0 1 01 FFFFFFFF
03A00002 1C000004 0 1 02 00000800
142468A3 1C000008 0 1 03 12345000
1C000024 1C00000C 0 1 04 1C00100C
0399E063 1C000010 0 1 03 12345678
00100866 1C000014 0 1 06 12345E78
00110447 1C000018 0 1 07 00000801
00120828 1C00001C 0 1 08 00000001
00128829 1C000020 0 1 09 00000000
0015846C 1C000024 0 1 0C EDCBA987
0014086D 1C000028 0 1 0D EDCBA187
0280900E 1C00002C 0 1 0E 00000024
0017386F 1C000030 0 1 0F 23456780
0017B830 1C000034 0 1 10 0FFFFFFF
001839B1 1C000038 0 1 11 FEDCBA18
0040A072 1C00003C 0 1 12 34567800
0048C1B4 1C000040 0 1 14 FFFFEDCB
02801419 1C000044 0 1 19 00000005
00106739 1C000048 0 1 19 0000000A
00110B3A 1C00004C 0 1 1A FFFFF80A
00108019 1C000050 1 0 19 00000000
0380033B 1C000054 0 1 1B 0000000A
00000000 1C000058 0 0 00 00000000
02848C20 1C00005C 0 1 00 00000122
0010001C 1C000060 0 1 1C 00000000

/* la_int_core.f */
+incdir+include
hw/la_pkg.sv
hw/la_decode.sv
hw/la_execute.sv
hw/la_writeback.sv
hw/la_int_core.sv
tests/la_int_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the la_int_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module la_int_core_tb -f la_int_core.f -o la_int_core_sim

if ./obj_dir/la_int_core_sim 2>&1 | tee /dev/stderr | grep "^Simulation passed$" > /dev/null; then
    echo "run_sim: ok"
else
    echo "run_sim: failing run" >&2
    exit 1
fi

/* tests/la_int_core_tb.sv */
`timescale 1ns/1ps

module la_int_core_tb;

    typedef struct packed {
        la_pkg::fetch_t  fetch;
        la_pkg::result_t res;    // expected result.
    } vector_t;

    typedef struct packed {
        la_pkg::result_t res;
        int unsigned     cycle;  // edge count at which the result must show.
    } expect_t;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    la_pkg::fetch_t  in_fetch;
    logic            res_valid;
    la_pkg::result_t res;

    vector_t     vectors[$];
    expect_t     exp_q[$];
    int unsigned cycle = 0;
    bit          loaded = 1'b0;

    la_int_core la_int_core_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_fetch  (in_fetch),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic value_error(string msg);
        fail_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_inst, f_pc, f_ine, f_we, f_rd, f_value;
        vector_t     v;
        fd = $fopen("tests/la_int_core_golden.txt", "r");
        if (fd == 0) fail_run("could not open tests/la_int_core_golden.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h", f_inst, f_pc, f_ine, f_we, f_rd, f_value);
                if (n != 6) fail_run($sformatf("malformed line in golden file: %s", line));
                v.fetch.pc   = f_pc;
                v.fetch.inst = f_inst;
                v.res.pc     = f_pc;
                v.res.rd     = f_rd[4:0];
                v.res.value  = f_value;
                v.res.we     = f_we[0];
                v.res.ine    = f_ine[0];
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) fail_run("the golden file holds no vectors");
    endtask

    task automatic check_result();
        expect_t e;
        assert (exp_q.size() != 0)
            else fail_run("a result came out with no instruction outstanding");
        e = exp_q.pop_front();
        assert (cycle == e.cycle)
            else value_error($sformatf("pc %h result at cycle %0d, expected cycle %0d",
                                       res.pc, cycle, e.cycle));
        assert (res.pc == e.res.pc)
            else value_error($sformatf("pc %h, expected %h", res.pc, e.res.pc));
        assert (res.ine == e.res.ine)
            else value_error($sformatf("pc %h ine %b, expected %b", res.pc, res.ine, e.res.ine));
        assert (res.we == e.res.we)
            else value_error($sformatf("pc %h we %b, expected %b", res.pc, res.we, e.res.we));
        assert (res.rd == e.res.rd)
            else value_error($sformatf("pc %h rd %0d, expected %0d", res.pc, res.rd, e.res.rd));
        if (e.res.we) begin  // no value is defined for a result that writes nothing.
            assert (res.value == e.res.value)
                else value_error($sformatf("pc %h value %h, expected %h",
                                           res.pc, res.value, e.res.value));
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && res_valid) check_result();
    end

    // 4 cycles per vector covers the worst gap plus latency.
    initial begin
        wait (loaded);
        repeat (10 + 4 * vectors.size() + 50) @(posedge clk);
        fail_run("timeout, the results did not all come back in time");
    end

    initial begin
        int unsigned gap;
        expect_t     e;
        void'($urandom(50));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_fetch = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (vectors[i]) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_fetch = vectors[i].fetch;
            e.res    = vectors[i].res;
            e.cycle  = cycle + 2;  // two register stages after this cycle.
            exp_q.push_back(e);
            gap = $urandom % 3;
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d results never came out", exp_q.size()));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* hw/la_int_core.sv */
`timescale 1ns/1ps

module la_int_core (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  la_pkg::fetch_t  in_fetch,
    output logic            res_valid,
    output la_pkg::result_t res
);

    logic              dec_valid;
    la_pkg::decoded_t  dec;
    la_pkg::reg_addr_t rj_addr;
    la_pkg::reg_addr_t rk_addr;
    la_pkg::word_t     rj_data;
    la_pkg::word_t     rk_data;

    la_decode la_decode_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_fetch  (in_fetch),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    la_execute la_execute_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rj_addr   (rj_addr),
        .rk_addr   (rk_addr),
        .rj_data   (rj_data),
        .rk_data   (rk_data),
        .ex_valid  (res_valid),
        .ex        (res)
    );

    // result strobe doubles as the write request.
    la_writeback la_writeback_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .ex_valid (res_valid),
        .ex       (res),
        .rj_addr  (rj_addr),
        .rk_addr  (rk_addr),
        .rj_data  (rj_data),
        .rk_data  (rk_data)
    );

endmodule

/* hw/la_writeback.sv */
`timescale 1ns/1ps
`include "la_cfg.svh"

module la_writeback (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_valid,
    input  la_pkg::result_t   ex,
    input  la_pkg::reg_addr_t rj_addr,
    input  la_pkg::reg_addr_t rk_addr,
    output la_pkg::word_t     rj_data,
    output la_pkg::word_t     rk_data
);

    la_pkg::word_t regs [`LA_NREGS];
    logic          wr_en;

    // r0 is hardwired, so it is never a write target.
    assign wr_en = ex_valid && ex.we && (ex.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LA_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex.rd] <= ex.value;
        end
    end

    // pending write is forwarded until it lands.
    assign rj_data = (wr_en && ex.rd == rj_addr) ? ex.value : regs[rj_addr];
    assign rk_data = (wr_en && ex.rd == rk_addr) ? ex.value : regs[rk_addr];

    a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        regs[0] == '0);

endmodule

/* hw/la_execute.sv */
`timescale 1ns/1ps
`include "la_cfg.svh"

module la_execute (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                dec_valid,
    input  la_pkg::decoded_t    dec,
    output la_pkg::reg_addr_t   rj_addr,
    output la_pkg::reg_addr_t   rk_addr,
    input  la_pkg::word_t       rj_data,
    input  la_pkg::word_t       rk_data,
    output logic                ex_valid,
    output la_pkg::result_t     ex
);

    la_pkg::word_t           op1;
    la_pkg::word_t           op2;
    logic [`LA_SHAMT_W-1:0]  shamt;
    la_pkg::word_t           alu_out;

    assign rj_addr = dec.rj;
    assign rk_addr = dec.rk;

    assign op1   = dec.use_pc ? dec.pc : rj_data;
    assign op2   = dec.use_imm ? dec.imm : rk_data;
    assign shamt = op2[`LA_SHAMT_W-1:0];  // only the low bits count.

    always_comb begin
        case (dec.op)
            la_pkg::alu_add:  alu_out = op1 + op2;
            la_pkg::alu_sub:  alu_out = op1 - op2;
            la_pkg::alu_slt:  alu_out = {{(`LA_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            la_pkg::alu_sltu: alu_out = {{(`LA_XLEN-1){1'b0}}, op1 < op2};
            la_pkg::alu_and:  alu_out = op1 & op2;
            la_pkg::alu_or:   alu_out = op1 | op2;
            la_pkg::alu_xor:  alu_out = op1 ^ op2;
            la_pkg::alu_nor:  alu_out = ~(op1 | op2);
            la_pkg::alu_sll:  alu_out = op1 << shamt;
            la_pkg::alu_srl:  alu_out = op1 >> shamt;
            la_pkg::alu_sra:  alu_out = la_pkg::word_t'($signed(op1) >>> shamt);
            la_pkg::alu_lui:  alu_out = op2;
            default:          alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex       <= '0;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid) begin
                ex.pc    <= dec.pc;
                ex.rd    <= dec.rd;
                ex.value <= alu_out;
                ex.we    <= dec.we;
                ex.ine   <= dec.ine;
            end
        end
    end

    a_ex_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(ex_valid));

endmodule

/* hw/la_decode.sv */
`timescale 1ns/1ps
`include "la_cfg.svh"

module la_decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  la_pkg::fetch_t   in_fetch,
    output logic             dec_valid,
    output la_pkg::decoded_t dec
);

    logic [9:0]  opcode10;
    logic [16:0] opcode17;
    logic [6:0]  opcode7;
    logic [19:0] si20;
    logic [11:0] i12;
    logic [4:0]  ui5;

    la_pkg::word_t imm_si12;
    la_pkg::word_t imm_ui12;
    la_pkg::word_t imm_ui5;
    la_pkg::word_t imm_si20;

    la_pkg::alu_op_t  op;
    la_pkg::word_t    imm;
    logic             use_imm;
    logic             use_pc;
    logic             hit10;
    logic             hit17;
    logic             hit7;
    logic             matched;
    la_pkg::decoded_t dec_next;

    assign opcode10 = in_fetch.inst[31:22];
    assign opcode17 = in_fetch.inst[31:15];
    assign opcode7  = in_fetch.inst[31:25];
    assign si20     = in_fetch.inst[24:5];
    assign i12      = in_fetch.inst[21:10];
    assign ui5      = in_fetch.inst[14:10];

    assign imm_si12 = {{(`LA_XLEN-12){i12[11]}}, i12};
    assign imm_ui12 = {{(`LA_XLEN-12){1'b0}}, i12};
    assign imm_ui5  = {{(`LA_XLEN-5){1'b0}}, ui5};
    assign imm_si20 = {si20, 12'b0};

    always_comb begin
        op      = la_pkg::alu_add;
        imm     = imm_si12;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        hit10   = 1'b1;
        hit17   = 1'b1;
        hit7    = 1'b1;

        case (opcode10)
            `LA_OP_SLTI:   op = la_pkg::alu_slt;
            `LA_OP_SLTUI:  op = la_pkg::alu_sltu;
            `LA_OP_ADDI_W: op = la_pkg::alu_add;
            `LA_OP_ANDI:   op = la_pkg::alu_and;
            `LA_OP_ORI:    op = la_pkg::alu_or;
            `LA_OP_XORI:   op = la_pkg::alu_xor;
            default:       hit10 = 1'b0;
        endcase
        if (hit10) begin
            use_imm = 1'b1;
            // logic immediates are zero-extended.
            if (opcode10 inside {`LA_OP_ANDI, `LA_OP_ORI, `LA_OP_XORI}) begin
                imm = imm_ui12;
            end
        end

        case (opcode17)
            `LA_OP_ADD_W:  op = la_pkg::alu_add;
            `LA_OP_SUB_W:  op = la_pkg::alu_sub;
            `LA_OP_SLT:    op = la_pkg::alu_slt;
            `LA_OP_SLTU:   op = la_pkg::alu_sltu;
            `LA_OP_NOR:    op = la_pkg::alu_nor;
            `LA_OP_AND:    op = la_pkg::alu_and;
            `LA_OP_OR:     op = la_pkg::alu_or;
            `LA_OP_XOR:    op = la_pkg::alu_xor;
            `LA_OP_SLL_W,
            `LA_OP_SLLI_W: op = la_pkg::alu_sll;
            `LA_OP_SRL_W,
            `LA_OP_SRLI_W: op = la_pkg::alu_srl;
            `LA_OP_SRA_W,
            `LA_OP_SRAI_W: op = la_pkg::alu_sra;
            default:       hit17 = 1'b0;
        endcase
        if (opcode17 inside {`LA_OP_SLLI_W, `LA_OP_SRLI_W, `LA_OP_SRAI_W}) begin
            use_imm = 1'b1;
            imm     = imm_ui5;
        end

        case (opcode7)
            `LA_OP_LU12I_W:   op = la_pkg::alu_lui;
            `LA_OP_PCADDU12I: use_pc = 1'b1;  // pc + imm through the adder.
            default:          hit7 = 1'b0;
        endcase
        if (hit7) begin
            use_imm = 1'b1;
            imm     = imm_si20;
        end
    end

    assign matched = hit10 | hit17 | hit7;

    assign dec_next.pc      = in_fetch.pc;
    assign dec_next.op      = op;
    assign dec_next.rj      = in_fetch.inst[9:5];
    assign dec_next.rk      = in_fetch.inst[14:10];
    assign dec_next.rd      = in_fetch.inst[4:0];
    assign dec_next.imm     = imm;
    assign dec_next.use_imm = use_imm;
    assign dec_next.use_pc  = use_pc;
    assign dec_next.we      = matched;
    // all-zero word is a bubble, not a fault.
    assign dec_next.ine     = !matched && (in_fetch.inst != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= in_valid;
            if (in_valid) begin
                dec <= dec_next;
            end
        end
    end

    a_ine_no_we: assert property (@(posedge clk) disable iff (!arst_n)
        dec_valid |-> !(dec.ine && dec.we));

endmodule

/* hw/la_pkg.sv */
`include "la_cfg.svh"

package la_pkg;

    typedef logic [`LA_XLEN-1:0] word_t;
    typedef logic [31:0] inst_t;  // fixed width for la32.
    typedef logic [$clog2(`LA_NREGS)-1:0] reg_addr_t;
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_slt  = 4'd2;
    localparam alu_op_t alu_sltu = 4'd3;
    localparam alu_op_t alu_and  = 4'd4;
    localparam alu_op_t alu_or   = 4'd5;
    localparam alu_op_t alu_xor  = 4'd6;
    localparam alu_op_t alu_nor  = 4'd7;
    localparam alu_op_t alu_sll  = 4'd8;
    localparam alu_op_t alu_srl  = 4'd9;
    localparam alu_op_t alu_sra  = 4'd10;
    localparam alu_op_t alu_lui  = 4'd11;  // operand 2 passes through.

    typedef struct packed {
        word_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   op;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
        word_t     imm;
        logic      use_imm;  // operand 2 is imm.
        logic      use_pc;   // operand 1 is pc.
        logic      we;
        logic      ine;
    } decoded_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     value;
        logic      we;
        logic      ine;
    } result_t;

endpackage

/* include/la_cfg.svh */
`ifndef LA_CFG_SVH
`define LA_CFG_SVH

`define LA_XLEN    32
`define LA_NREGS   32
`define LA_SHAMT_W 5

// 10-bit major opcode, inst[31:22].
`define LA_OP_SLTI    10'b0000001000
`define LA_OP_SLTUI   10'b0000001001
`define LA_OP_ADDI_W  10'b0000001010
`define LA_OP_ANDI    10'b0000001101
`define LA_OP_ORI     10'b0000001110
`define LA_OP_XORI    10'b0000001111

// 17-bit opcode, inst[31:15].
`define LA_OP_ADD_W   17'b00000000000100000
`define LA_OP_SUB_W   17'b00000000000100010
`define LA_OP_SLT     17'b00000000000100100
`define LA_OP_SLTU    17'b00000000000100101
`define LA_OP_NOR     17'b00000000000101000
`define LA_OP_AND     17'b00000000000101001
`define LA_OP_OR      17'b00000000000101010
`define LA_OP_XOR     17'b00000000000101011
`define LA_OP_SLL_W   17'b00000000000101110
`define LA_OP_SRL_W   17'b00000000000101111
`define LA_OP_SRA_W   17'b00000000000110000
`define LA_OP_SLLI_W  17'b00000000010000001
`define LA_OP_SRLI_W  17'b00000000010001001
`define LA_OP_SRAI_W  17'b00000000010010001

// 7-bit opcode, inst[31:25].
`define LA_OP_LU12I_W   7'b0001010
`define LA_OP_PCADDU12I 7'b0001110

`endif
